// File: dv/tb_irq.sv
module tb_irq;

	timeunit 1ns;
	timeprecision 100ps;

	import bus_pkg::*;
	import irq_pkg::*;

	localparam int n_src      = 5;
	localparam int clk_period = 8;

	// Loop counts and the cycles each test takes
	localparam int ie_iter    = 24;
	localparam int if_iter    = 32;
	localparam int disp_iter  = 16;
	localparam int gate_cyc   = 64;
	localparam int empty_iter = 8;
	localparam int mix_cyc    = 2000;
	localparam int total_cycles = 8 + 2 * ie_iter + 4 * if_iter + 6 * disp_iter +
		gate_cyc + 5 * empty_iter + mix_cyc;

	typedef logic [n_src-1:0] src_t;

	logic     clk = 1'b0;
	logic     rst;
	bus_req_t bus;
	src_t     req;
	logic     ime;
	logic     dispatch;
	data_t    rdata;
	logic     irq_req;
	logic     wake;
	irq_vec_t vec;

	logic [31:0] rng_state;
	int          test_err;
	int          err_cnt;
	int          check_cnt;
	int          tests_run;
	int          tests_failed;

	// Reference model state
	data_t       m_ie;
	src_t        m_if;
	logic        m_deliver; // Deliver cycle follows a dispatch
	src_t        m_win;
	logic [15:0] m_vector;
	logic        m_cancel;

	irq_top #(
		.n_src (n_src)
	) i_dut (
		.clk      (clk),
		.rst      (rst),
		.bus      (bus),
		.req      (req),
		.ime      (ime),
		.dispatch (dispatch),
		.rdata    (rdata),
		.irq_req  (irq_req),
		.wake     (wake),
		.vec      (vec)
	);

	always #(clk_period / 2) clk = ~clk;

	// 32-bit xorshift, state kept across calls
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic bus_req_t make_access(input addr_t a, input data_t d,
		input logic r, input logic w);
		bus_req_t b;
		b.addr  = a;
		b.wdata = d;
		b.rd    = r;
		b.wr    = w;
		return b;
	endfunction

	function automatic bus_req_t no_access();
		return make_access(16'h0000, 8'h00, 1'b0, 1'b0);
	endfunction

	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("error: %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
			test_err++;
		end
	endtask

	// Outputs predicted from model state and the inputs of this cycle
	task automatic check_outputs();
		src_t  pend;
		data_t exp_rdata;
		logic  exp_any;
		pend      = m_ie[n_src-1:0] & m_if;
		exp_any   = |pend;
		exp_rdata = 8'hff;
		if (bus.rd && bus.addr == addr_ie) begin
			exp_rdata = m_ie;
		end else if (bus.rd && bus.addr == addr_if) begin
			exp_rdata = {{(8 - n_src){1'b1}}, m_if}; // Unused bits read 1
		end
		compare("rdata", rdata, exp_rdata);
		compare("wake", wake, exp_any);
		compare("irq_req", irq_req, exp_any & ime & ~m_deliver);
		compare("vec.valid", vec.valid, m_deliver);
		compare("vec.cancel", vec.cancel, m_deliver & m_cancel);
		compare("vec.vector", vec.vector, m_deliver ? m_vector : 16'h0000);
	endtask

	// Register state after the coming clock edge
	task automatic advance_model();
		src_t pend;
		src_t ack;
		src_t if_n;
		int   idx;
		pend = m_ie[n_src-1:0] & m_if;
		ack  = m_deliver ? m_win : '0;
		if_n = m_if & ~ack;
		if (bus.wr && bus.addr == addr_if) begin
			if_n = bus.wdata[n_src-1:0];
		end
		if_n = if_n | req; // Request beats clear and write
		if (bus.wr && bus.addr == addr_ie) begin
			m_ie = bus.wdata;
		end
		if (dispatch) begin
			idx = -1;
			for (int k = 0; k < n_src; k++) begin
				if (idx < 0 && pend[k]) begin
					idx = k;
				end
			end
			if (idx < 0) begin
				m_win    = '0;
				m_vector = 16'h0000;
				m_cancel = 1'b1;
			end else begin
				m_win    = src_t'(1) << idx;
				m_vector = 16'h0040 + 16'd8 * 16'(idx);
				m_cancel = 1'b0;
			end
		end
		m_if      = if_n;
		m_deliver = dispatch;
	endtask

	// One clock cycle, inputs change on the falling edge
	task automatic drive_cycle(input bus_req_t b, input src_t r, input logic i,
		input logic d);
		@(negedge clk);
		bus      = b;
		req      = r;
		ime      = i;
		dispatch = d;
		#1;
		check_outputs();
		advance_model();
	endtask

	task automatic start_test();
		test_err = 0;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_err == 0) begin
			$display("test %-16s pass", name);
		end else begin
			$display("test %-16s FAIL, %0d errors", name, test_err);
			tests_failed++;
		end
		err_cnt += test_err;
	endtask

	task automatic test_ie_readback();
		data_t val;
		for (int n = 0; n < ie_iter; n++) begin
			val = data_t'(next_rand());
			drive_cycle(make_access(addr_ie, val, 1'b0, 1'b1), '0, 1'b0, 1'b0);
			drive_cycle(make_access(addr_ie, 8'h00, 1'b1, 1'b0), '0, 1'b0, 1'b0);
			compare("rdata", rdata, val);
		end
	endtask

	task automatic test_if_set_write();
		logic [31:0] rnd;
		for (int n = 0; n < if_iter; n++) begin
			rnd = next_rand();
			drive_cycle(no_access(), src_t'(rnd[7:0]), 1'b0, 1'b0);
			drive_cycle(make_access(addr_if, 8'h00, 1'b1, 1'b0), '0, 1'b0, 1'b0);
			compare("rdata[7:5]", rdata[7:5], 3'b111);
			// Write and request pulses land in the same cycle
			drive_cycle(make_access(addr_if, rnd[15:8], 1'b0, 1'b1),
				src_t'(rnd[23:16] & rnd[31:24]), 1'b0, 1'b0);
			drive_cycle(make_access(addr_if, 8'h00, 1'b1, 1'b0), '0, 1'b0, 1'b0);
			compare("rdata[7:5]", rdata[7:5], 3'b111);
		end
	endtask

	task automatic test_dispatch_vector();
		src_t        r;
		data_t       ie_val;
		int          low;
		logic [15:0] exp_vec;
		for (int n = 0; n < disp_iter; n++) begin
			r = src_t'(next_rand());
			if (r == '0) begin
				r = src_t'(4);
			end
			ie_val = data_t'(next_rand()) | data_t'(r); // Every requested source enabled
			low = -1;
			for (int k = 0; k < n_src; k++) begin
				if (low < 0 && r[k]) begin
					low = k;
				end
			end
			exp_vec = 16'h0040 + 16'd8 * 16'(low);
			drive_cycle(make_access(addr_ie, ie_val, 1'b0, 1'b1), '0, 1'b1, 1'b0);
			drive_cycle(make_access(addr_if, 8'h00, 1'b0, 1'b1), '0, 1'b1, 1'b0);
			drive_cycle(no_access(), r, 1'b1, 1'b0);
			drive_cycle(no_access(), '0, 1'b1, 1'b1);
			drive_cycle(no_access(), '0, 1'b1, 1'b0);
			compare("vec.valid", vec.valid, 1'b1);
			compare("vec.vector", vec.vector, exp_vec);
			drive_cycle(make_access(addr_if, 8'h00, 1'b1, 1'b0), '0, 1'b1, 1'b0);
			compare("rdata winner bit", rdata[low], 1'b0);
		end
	endtask

	task automatic test_ime_gating();
		logic [31:0] rnd;
		logic        lvl;
		for (int n = 0; n < gate_cyc; n++) begin
			rnd = next_rand();
			lvl = (n >= gate_cyc / 2); // Low first, then high
			if (rnd[1:0] == 2'b00) begin
				drive_cycle(make_access(addr_ie, rnd[15:8], 1'b0, 1'b1), '0, lvl, 1'b0);
			end else if (rnd[1:0] == 2'b01) begin
				drive_cycle(make_access(addr_if, rnd[15:8], 1'b0, 1'b1), '0, lvl, 1'b0);
			end else begin
				drive_cycle(no_access(), src_t'(rnd[23:16] & rnd[31:24]), lvl, 1'b0);
			end
			if (!lvl) begin
				compare("irq_req", irq_req, 1'b0);
			end
		end
	endtask

	task automatic test_empty_dispatch();
		logic [31:0] rnd;
		data_t       ie_val;
		src_t        if_val;
		for (int n = 0; n < empty_iter; n++) begin
			rnd = next_rand();
			// Either no flags, or flags with no source enabled
			if (n % 2 == 0) begin
				ie_val = rnd[7:0];
				if_val = '0;
			end else begin
				ie_val = rnd[7:0] & 8'he0;
				if_val = src_t'(rnd[15:8]) | src_t'(1);
			end
			drive_cycle(make_access(addr_ie, ie_val, 1'b0, 1'b1), '0, rnd[16], 1'b0);
			drive_cycle(make_access(addr_if, data_t'(if_val), 1'b0, 1'b1), '0, rnd[16], 1'b0);
			drive_cycle(no_access(), '0, rnd[16], 1'b1);
			drive_cycle(no_access(), '0, rnd[16], 1'b0);
			compare("vec.valid", vec.valid, 1'b1);
			compare("vec.cancel", vec.cancel, 1'b1);
			compare("vec.vector", vec.vector, 16'h0000);
			drive_cycle(make_access(addr_if, 8'h00, 1'b1, 1'b0), '0, rnd[16], 1'b0);
			compare("rdata flags", rdata[n_src-1:0], if_val);
		end
	endtask

	task automatic test_random_mix();
		logic [31:0] rnd;
		logic [31:0] rnd_addr;
		addr_t       a;
		logic        rd;
		logic        wr;
		for (int n = 0; n < mix_cyc; n++) begin
			rnd      = next_rand();
			rnd_addr = next_rand();
			case (rnd[1:0])
				2'd0:    a = addr_ie;
				2'd1:    a = addr_if;
				default: a = rnd_addr[15:0];
			endcase
			rd = (rnd[3:2] == 2'd1) || (rnd[3:2] == 2'd3);
			wr = (rnd[3:2] == 2'd2); // Never together with rd
			drive_cycle(make_access(a, rnd[31:24], rd, wr),
				src_t'(rnd[8:4] & rnd[13:9] & rnd[18:14]),
				rnd[19] | rnd[20], rnd[22:21] == 2'b00);
		end
	endtask

	initial begin
		rst          = 1'b1;
		bus          = '0;
		req          = '0;
		ime          = 1'b0;
		dispatch     = 1'b0;
		rng_state    = 32'hfef8_3cec;
		test_err     = 0;
		err_cnt      = 0;
		check_cnt    = 0;
		tests_run    = 0;
		tests_failed = 0;
		m_ie         = '0;
		m_if         = '0;
		m_deliver    = 1'b0;
		m_win        = '0;
		m_vector     = 16'h0000;
		m_cancel     = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		start_test();
		test_ie_readback();
		finish_test("ie_readback");
		start_test();
		test_if_set_write();
		finish_test("if_set_write");
		start_test();
		test_dispatch_vector();
		finish_test("dispatch_vector");
		start_test();
		test_ime_gating();
		finish_test("ime_gating");
		start_test();
		test_empty_dispatch();
		finish_test("empty_dispatch");
		start_test();
		test_random_mix();
		finish_test("random_mix");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Twice the expected run time
	initial begin
		#(total_cycles * clk_period * 2);
		$display("watchdog: the tests did not finish within the time limit");
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: files.f
verilog/irq_pkg.sv
verilog/bus_pkg.sv
verilog/bus_decode.sv
verilog/irq_regs.sv
verilog/irq_prio.sv
verilog/irq_control.sv
verilog/irq_top.sv
dv/tb_irq.sv

// File: verilog/bus_decode.sv
module bus_decode (
	input  logic              clk,
	input  logic              rst,
	input  bus_pkg::bus_req_t bus,
	input  bus_pkg::data_t    ie_q,
	input  logic [7:0]        if_q,  // Already padded with 1s
	output bus_pkg::reg_sel_t sel,
	output bus_pkg::data_t    rdata
);

	import bus_pkg::*;

	logic hit_ie;
	logic hit_if;

	assign hit_ie = (bus.addr == addr_ie); // 0xFFFF
	assign hit_if = (bus.addr == addr_if); // 0xFF0F

	// Qualify address hits with the strobes
	always_comb begin
		sel.ie_wr = hit_ie & bus.wr;
		sel.if_wr = hit_if & bus.wr;
		sel.ie_rd = hit_ie & bus.rd;
		sel.if_rd = hit_if & bus.rd;
	end

	// Read mux, open bus reads back as all ones
	always_comb begin
		rdata = 8'hff;
		if (sel.ie_rd) begin
			rdata = ie_q;
		end else if (sel.if_rd) begin
			rdata = if_q;
		end
	end

	// CPU never reads and writes in one cycle
	assert property (@(posedge clk) disable iff (rst) !(bus.rd && bus.wr))
		else $error("bus_decode: rd and wr high together");

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

	localparam int data_w = 8;
	localparam int addr_w = 16;

	typedef logic [data_w-1:0] data_t;
	typedef logic [addr_w-1:0] addr_t;

	// One CPU access, strobes are single cycle
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;
		logic  wr;
	} bus_req_t;

	localparam addr_t addr_ie = 16'hffff; // Interrupt enable
	localparam addr_t addr_if = 16'hff0f; // Interrupt flags

	// Decoded register strobes
	typedef struct packed {
		logic ie_wr;
		logic if_wr;
		logic ie_rd;
		logic if_rd;
	} reg_sel_t;

endpackage

// File: verilog/irq_control.sv
module irq_control #(
	parameter int n_src = 5
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              ime,      // Master enable level from the CPU
	input  logic              dispatch, // CPU starts an interrupt entry
	input  logic              any_pend,
	input  logic [2:0]        win_idx,
	input  logic [n_src-1:0]  win_onehot,
	output logic [n_src-1:0]  ack_clr,
	output logic              irq_req,
	output logic              wake,
	output irq_pkg::irq_vec_t vec
);

	import irq_pkg::*;

	typedef enum logic {
		st_idle,
		st_deliver
	} state_t;

	state_t           state;
	state_t           state_nxt;
	logic [n_src-1:0] win_r;    // Captured winner
	logic [15:0]      vector_r;
	logic             cancel_r;

	// Deliver lasts one cycle, a new dispatch restarts it
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (dispatch) begin
					state_nxt = st_deliver;
				end
			end
			st_deliver: begin
				state_nxt = dispatch ? st_deliver : st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// Snapshot the winner on the dispatch edge
	always_ff @(posedge clk) begin
		if (dispatch) begin
			win_r    <= any_pend ? win_onehot : '0;
			vector_r <= any_pend ? irq_vector(win_idx) : 16'h0000;
			cancel_r <= ~any_pend; // Flag went away before entry
		end
	end

	// Result and flag clear both pulse in the deliver cycle
	always_comb begin
		vec.valid  = (state == st_deliver);
		vec.cancel = vec.valid & cancel_r;
		vec.vector = vec.valid ? vector_r : 16'h0000;
	end

	assign ack_clr = (state == st_deliver) ? win_r : '0;

	assign wake    = any_pend; // Halt ends regardless of IME
	assign irq_req = any_pend & ime & (state == st_idle);

	// At most one flag is cleared per dispatch
	assert property (@(posedge clk) disable iff (rst) $onehot0(ack_clr))
		else $error("irq_control: ack_clr not one-hot");

endmodule

// File: verilog/irq_pkg.sv
package irq_pkg;

	localparam int n_src_default = 5; // VBLANK, STAT, timer, serial, joypad

	// Restart vectors sit 8 bytes apart from 0x0040
	localparam logic [15:0] vec_base = 16'h0040;
	localparam logic [15:0] vec_step = 16'h0008;

	typedef struct packed {
		logic        valid;  // One-cycle dispatch result
		logic        cancel; // Dispatch found nothing pending
		logic [15:0] vector; // Restart address, 0 on cancel
	} irq_vec_t;

	// Restart address for a source index
	function automatic logic [15:0] irq_vector(input logic [2:0] idx);
		logic [15:0] offs;
		offs = vec_step * {13'd0, idx};
		return vec_base + offs;
	endfunction

endpackage

// File: verilog/irq_prio.sv
module irq_prio #(
	parameter int n_src = 5
) (
	input  logic [7:0]       ie_q,
	input  logic [7:0]       if_q,
	output logic             any_pend,
	output logic [2:0]       win_idx,
	output logic [n_src-1:0] win_onehot
);

	logic [n_src-1:0] pend;

	assign pend = ie_q[n_src-1:0] & if_q[n_src-1:0]; // Enabled and flagged
	assign any_pend = |pend;

	// Isolate lowest set bit, source 0 has top priority
	assign win_onehot = pend & (~pend + 1'b1);

	// Scan from the top so the lowest index is left last
	always_comb begin
		win_idx = '0;
		for (int i = n_src - 1; i >= 0; i--) begin
			if (pend[i]) begin
				win_idx = 3'(i);
			end
		end
	end

	// Winner is one-hot or zero and names the same source as the index
	always_comb begin
		assert final (win_onehot == (any_pend ? (n_src'(1'b1) << win_idx) : '0))
			else $error("irq_prio: winner %b disagrees with index %0d for pend %b",
				win_onehot, win_idx, pend);
	end

endmodule

// File: verilog/irq_regs.sv
module irq_regs #(
	parameter int n_src = 5
) (
	input  logic              clk,
	input  logic              rst,
	input  bus_pkg::reg_sel_t sel,
	input  bus_pkg::data_t    wdata,
	input  logic [n_src-1:0]  req,     // One-cycle request pulses
	input  logic [n_src-1:0]  ack_clr, // One-hot clear from dispatch
	output bus_pkg::data_t    ie_q,
	output logic [7:0]        if_q
);

	import bus_pkg::*;

	data_t            ie_r;   // All 8 IE bits are stored
	logic [n_src-1:0] if_r;
	logic [n_src-1:0] if_nxt;

	// IE is plain read/write
	always_ff @(posedge clk) begin
		if (rst) begin
			ie_r <= '0;
		end else if (sel.ie_wr) begin
			ie_r <= wdata;
		end
	end

	// IF update order is clear, then write, then set
	always_comb begin
		if_nxt = if_r & ~ack_clr;
		if (sel.if_wr) begin
			if_nxt = wdata[n_src-1:0];
		end
		if_nxt = if_nxt | req; // Request wins over clear and write
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			if_r <= '0;
		end else begin
			if_r <= if_nxt;
		end
	end

	assign ie_q = ie_r;

	// Unused flag bits read back as 1
	always_comb begin
		if_q = 8'hff;
		if_q[n_src-1:0] = if_r;
	end

endmodule

// File: verilog/irq_top.sv
module irq_top #(
	parameter int n_src = irq_pkg::n_src_default
) (
	input  logic              clk,
	input  logic              rst,
	input  bus_pkg::bus_req_t bus,
	input  logic [n_src-1:0]  req,
	input  logic              ime,
	input  logic              dispatch,
	output bus_pkg::data_t    rdata,
	output logic              irq_req,
	output logic              wake,
	output irq_pkg::irq_vec_t vec
);

	import bus_pkg::*;

	reg_sel_t         sel;
	data_t            ie_q;
	logic [7:0]       if_q;       // Padded flag view
	logic             any_pend;
	logic [2:0]       win_idx;
	logic [n_src-1:0] win_onehot;
	logic [n_src-1:0] ack_clr;

	// IF is one byte wide
	if (n_src < 1 || n_src > 8) begin : g_bad_n_src
		$error("irq_top: n_src must be 1 to 8, got %0d", n_src);
	end

	bus_decode i_bus_decode (
		.clk   (clk),
		.rst   (rst),
		.bus   (bus),
		.ie_q  (ie_q),
		.if_q  (if_q),
		.sel   (sel),
		.rdata (rdata)
	);

	irq_regs #(
		.n_src (n_src)
	) i_irq_regs (
		.clk     (clk),
		.rst     (rst),
		.sel     (sel),
		.wdata   (bus.wdata),
		.req     (req),
		.ack_clr (ack_clr),
		.ie_q    (ie_q),
		.if_q    (if_q)
	);

	irq_prio #(
		.n_src (n_src)
	) i_irq_prio (
		.ie_q       (ie_q),
		.if_q       (if_q),
		.any_pend   (any_pend),
		.win_idx    (win_idx),
		.win_onehot (win_onehot)
	);

	irq_control #(
		.n_src (n_src)
	) i_irq_control (
		.clk        (clk),
		.rst        (rst),
		.ime        (ime),
		.dispatch   (dispatch),
		.any_pend   (any_pend),
		.win_idx    (win_idx),
		.win_onehot (win_onehot),
		.ack_clr    (ack_clr),
		.irq_req    (irq_req),
		.wake       (wake),
		.vec        (vec)
	);

	// A real vector always clears the flag that produced it
	assert property (@(posedge clk) disable iff (rst)
		(vec.valid && !vec.cancel) |-> (ack_clr != '0))
		else $error("irq_top: vector delivered without flag clear");

endmodule
